// ==== design/frameGenPkg.sv ====
`default_nettype none

package frameGenPkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int BYTE_W   = 8;
  localparam int STAMP_W  = 24;  // period, event and time counters
  localparam int FRAMES_W = 8;   // frames per burst

  localparam int PERIOD_TICKS = 4096;  // wrap value of the period counter

  // ----------------------------------------------------------
  // frame shape
  // ----------------------------------------------------------
  localparam int RECORDS_PER_FRAME = 16;  // also the length field
  localparam int RECORD_BYTES      = 5;
  localparam int TAG_BYTES         = 10;  // header or footer
  localparam int BYTE_IDX_W        = $clog2(TAG_BYTES);
  localparam int REC_IDX_W         = $clog2(RECORDS_PER_FRAME);

  localparam logic [1:0] HEADER_MARK = 2'b10;
  localparam logic [1:0] RECORD_MARK = 2'b00;
  localparam logic [1:0] FOOTER_MARK = 2'b11;

  localparam logic [BYTE_W-1:0] FRONTEND_ADDR = 8'hAA;

  // fixed dummy hit, same for every record slot
  localparam logic [RECORD_BYTES*BYTE_W-1:0] HIT_RECORD = {
    RECORD_MARK,
    5'd4,      // asic id
    7'd28,     // channel
    13'h1555,  // leading edge
    13'h00E0   // trailing edge
  };

  // byte fifo
  localparam int FIFO_DEPTH    = 256;
  localparam int FIFO_AF_LEVEL = 240;  // almost full at this many entries
  localparam int FIFO_AW       = $clog2(FIFO_DEPTH);

  // 80 bit header / footer word, bytes[TAG_BYTES-1] goes out first
  typedef union packed {
    struct packed {
      logic [1:0]         marker;
      logic [BYTE_W-1:0]  address;
      logic [1:0]         mode;
      logic               zeroSuppress;
      logic [STAMP_W-8:0] spare;        // 17 bits, always zero
      logic               timeWindow;
      logic [STAMP_W-1:0] eventNumber;
      logic               last;         // final frame of the burst
      logic [STAMP_W-1:0] length;
    } hdr;
    struct packed {
      logic [1:0]         marker;
      logic [BYTE_W-1:0]  address;
      logic [1:0]         mode;
      logic               zeroSuppress;
      logic [STAMP_W-8:0] timeStamp;    // time bits 23..7
      logic               timeWindow;
      logic [STAMP_W-1:0] eventNumber;
      logic               last;
      logic [STAMP_W-1:0] length;
    } ftr;
    logic [TAG_BYTES-1:0][BYTE_W-1:0] bytes;
  } frameTag_u;

  typedef enum logic [1:0] {
    stIdle,
    stHeader,
    stRecord,
    stFooter
  } builderState_e;

endpackage

`default_nettype wire

// ==== design/burstTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module burstTimer import frameGenPkg::*; (
  input  wire                 CLK,
  input  wire                 RST,
  input  wire                 nimIn,
  input  wire                 regTrigger,
  output logic                nimOut,
  output logic                startPulse,
  output logic [STAMP_W-1:0]  eventNumber,
  output logic [STAMP_W-1:0]  timeStamp
);

  logic               armed;
  logic [STAMP_W-1:0] periodCnt;

  // either trigger source arms the generator
  assign armed = nimIn | regTrigger;

  // ----------------------------------------------------------
  // nim echo
  // ----------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      nimOut <= 1'b0;
    end else begin
      nimOut <= armed;  // one cycle behind the trigger
    end
  end

  // ----------------------------------------------------------
  // period and event counters
  // ----------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST || !armed) begin
      periodCnt   <= STAMP_W'(1);  // first tick a full period after arming
      eventNumber <= '0;
    end else if (periodCnt == STAMP_W'(PERIOD_TICKS)) begin
      periodCnt   <= '0;
      eventNumber <= eventNumber + 1'b1;  // new event on each wrap
    end else begin
      periodCnt <= periodCnt + 1'b1;
    end
  end

  // one cycle wide, period counter only sits at zero for one clock
  assign startPulse = armed && (periodCnt == '0);

  // time since the last burst start
  always_ff @(posedge CLK) begin
    if (RST || !armed) begin
      timeStamp <= '0;
    end else if (startPulse) begin
      timeStamp <= STAMP_W'(1);
    end else if (timeStamp != '0) begin
      // counts up, sticks at all ones
      timeStamp <= timeStamp + {{(STAMP_W-1){1'b0}}, ~&timeStamp};
    end
  end

endmodule

`default_nettype wire

// ==== design/frameBuilder.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameBuilder import frameGenPkg::*; (
  input  wire                 CLK,
  input  wire                 RST,
  input  wire                 startPulse,
  input  wire  [FRAMES_W-1:0] frameCount,
  input  wire  [STAMP_W-1:0]  eventNumber,
  input  wire  [STAMP_W-1:0]  timeStamp,
  input  wire                 almostFull,
  output logic                wrEn,
  output logic [BYTE_W-1:0]   wrData
);

  builderState_e         state;
  logic [BYTE_IDX_W-1:0] byteIdx;     // byte within tag or record
  logic [REC_IDX_W-1:0]  recordIdx;   // record within frame
  logic [FRAMES_W-1:0]   framesLeft;  // frames still to send, incl. current
  logic [STAMP_W-1:0]    evLatch;     // event number of this burst
  logic [STAMP_W-8:0]    stampLatch;  // footer time field
  logic                  lastFrame;
  logic                  stepEn;
  frameTag_u             tag;
  logic [BYTE_IDX_W-1:0] tagSel;
  logic [BYTE_IDX_W-1:0] recSel;

  assign lastFrame = (framesLeft == FRAMES_W'(1));
  assign stepEn    = !almostFull;  // whole FSM freezes on almost full

  // ----------------------------------------------------------
  // output byte
  // ----------------------------------------------------------
  always_comb begin
    tag = '0;  // mode, zero suppress, spare, time window
    if (state == stFooter) begin
      tag.ftr.marker      = FOOTER_MARK;
      tag.ftr.address     = FRONTEND_ADDR;
      tag.ftr.timeStamp   = stampLatch;
      tag.ftr.eventNumber = evLatch;
      tag.ftr.last        = lastFrame;
      tag.ftr.length      = STAMP_W'(RECORDS_PER_FRAME);
    end else begin
      tag.hdr.marker      = HEADER_MARK;
      tag.hdr.address     = FRONTEND_ADDR;
      tag.hdr.eventNumber = evLatch;
      tag.hdr.last        = lastFrame;
      tag.hdr.length      = STAMP_W'(RECORDS_PER_FRAME);
    end
  end

  // msb first for both tags and records
  assign tagSel = BYTE_IDX_W'(TAG_BYTES - 1) - byteIdx;
  assign recSel = BYTE_IDX_W'(RECORD_BYTES - 1) - byteIdx;

  always_comb begin
    if (state == stRecord) begin
      wrData = HIT_RECORD[recSel*BYTE_W +: BYTE_W];
    end else begin
      wrData = tag.bytes[tagSel];
    end
  end

  assign wrEn = (state != stIdle) && stepEn;  // one byte per active cycle

  // ----------------------------------------------------------
  // sequencing
  // ----------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      state      <= stIdle;
      byteIdx    <= '0;
      recordIdx  <= '0;
      framesLeft <= '0;
    end else if (stepEn) begin
      case (state)
        stIdle: begin
          byteIdx   <= '0;
          recordIdx <= '0;
          // pulses arriving mid-burst are simply missed
          if (startPulse && frameCount != '0) begin
            framesLeft <= frameCount;
            state      <= stHeader;
          end
        end
        stHeader: begin
          if (byteIdx == BYTE_IDX_W'(TAG_BYTES - 1)) begin
            byteIdx   <= '0;
            recordIdx <= '0;
            state     <= stRecord;
          end else begin
            byteIdx <= byteIdx + 1'b1;
          end
        end
        stRecord: begin
          if (byteIdx == BYTE_IDX_W'(RECORD_BYTES - 1)) begin
            byteIdx <= '0;
            if (recordIdx == REC_IDX_W'(RECORDS_PER_FRAME - 1)) begin
              state <= stFooter;
            end else begin
              recordIdx <= recordIdx + 1'b1;
            end
          end else begin
            byteIdx <= byteIdx + 1'b1;
          end
        end
        stFooter: begin
          if (byteIdx == BYTE_IDX_W'(TAG_BYTES - 1)) begin
            byteIdx <= '0;
            if (lastFrame) begin
              state <= stIdle;
            end else begin
              framesLeft <= framesLeft - 1'b1;
              state      <= stHeader;  // next frame right away
            end
          end else begin
            byteIdx <= byteIdx + 1'b1;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // burst event number and per-frame footer time
  always_ff @(posedge CLK) begin
    if (stepEn && state == stIdle && startPulse) begin
      evLatch <= eventNumber;
    end
    if (stepEn && state == stFooter && byteIdx == '0) begin
      stampLatch <= timeStamp[STAMP_W-1:7];  // used from footer byte 1 on
    end
  end

endmodule

`default_nettype wire

// ==== design/txByteFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module txByteFifo import frameGenPkg::*; (
  input  wire                CLK,
  input  wire                RST,
  input  wire                wrEn,
  input  wire  [BYTE_W-1:0]  wrData,
  input  wire                txFull,
  output logic               almostFull,
  output logic               txWr,
  output logic [BYTE_W-1:0]  txData
);

  logic [BYTE_W-1:0]  mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wrPtr;
  logic [FIFO_AW-1:0] rdPtr;
  logic [FIFO_AW:0]   count;  // occupancy, one bit wider than pointers
  logic               doWr;
  logic               doRd;

  assign doWr = wrEn && (count != (FIFO_AW+1)'(FIFO_DEPTH));  // drop when full
  assign doRd = !txFull && (count != '0);  // drain whenever tcp side has room

  assign almostFull = (count >= (FIFO_AW+1)'(FIFO_AF_LEVEL));

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (doWr) begin
      mem[wrPtr] <= wrData;
    end
  end

  // pointers wrap by themselves, depth is a power of two
  always_ff @(posedge CLK) begin
    if (RST) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWr) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doRd) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doWr, doRd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

  // ----------------------------------------------------------
  // tcp side
  // ----------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      txWr <= 1'b0;
    end else begin
      txWr <= doRd;  // valid one cycle after the read
    end
  end

  always_ff @(posedge CLK) begin
    if (doRd) begin
      txData <= mem[rdPtr];
    end
  end

endmodule

`default_nettype wire

// ==== design/frameSource.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameSource import frameGenPkg::*; (
  input  wire                 CLK,
  input  wire                 RST,
  input  wire                 nimIn,
  input  wire                 regTrigger,
  input  wire  [FRAMES_W-1:0] frameCount,
  input  wire                 txFull,
  output wire                 nimOut,
  output wire                 txWr,
  output wire  [BYTE_W-1:0]   txData
);

  // timer to builder
  wire               startPulse;
  wire [STAMP_W-1:0] eventNumber;
  wire [STAMP_W-1:0] timeStamp;

  // builder to fifo
  wire               wrEn;
  wire [BYTE_W-1:0]  wrData;
  wire               almostFull;  // back to builder

  burstTimer i_burstTimer (
    .CLK         (CLK),
    .RST         (RST),
    .nimIn       (nimIn),
    .regTrigger  (regTrigger),
    .nimOut      (nimOut),
    .startPulse  (startPulse),
    .eventNumber (eventNumber),
    .timeStamp   (timeStamp)
  );

  frameBuilder i_frameBuilder (
    .CLK         (CLK),
    .RST         (RST),
    .startPulse  (startPulse),
    .frameCount  (frameCount),
    .eventNumber (eventNumber),
    .timeStamp   (timeStamp),
    .almostFull  (almostFull),
    .wrEn        (wrEn),
    .wrData      (wrData)
  );

  txByteFifo i_txByteFifo (
    .CLK        (CLK),
    .RST        (RST),
    .wrEn       (wrEn),
    .wrData     (wrData),
    .txFull     (txFull),
    .almostFull (almostFull),
    .txWr       (txWr),
    .txData     (txData)
  );

endmodule

`default_nettype wire

// ==== tests/frameSource_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module builderRules import frameGenPkg::*; (
  input wire                  CLK,
  input wire                  RST,
  input wire [1:0]            state,
  input wire [BYTE_IDX_W-1:0] byteIdx,
  input wire                  almostFull,
  input wire                  wrEn,
  input wire [BYTE_W-1:0]     wrData
);

  int unsigned afFails   = 0;
  int unsigned idleFails = 0;
  int unsigned markFails = 0;

  // builder freezes while the fifo is almost full
  noWriteOnAlmostFull: assert property (@(posedge CLK) disable iff (RST)
    almostFull |-> !wrEn)
    else begin
      afFails++;
      $error("frameBuilder wrote while almostFull was high");
    end

  noWriteWhenIdle: assert property (@(posedge CLK) disable iff (RST)
    (state == stIdle) |-> !wrEn)
    else begin
      idleFails++;
      $error("frameBuilder wrote while idle");
    end

  // first header byte carries the marker in its top bits
  headerMarkFirst: assert property (@(posedge CLK) disable iff (RST)
    (state == stHeader && byteIdx == '0 && wrEn) |-> (wrData[BYTE_W-1 -: 2] == HEADER_MARK))
    else begin
      markFails++;
      $error("header did not start with HEADER_MARK");
    end

endmodule

bind frameBuilder builderRules i_builderRules (
  .CLK        (CLK),
  .RST        (RST),
  .state      (state),
  .byteIdx    (byteIdx),
  .almostFull (almostFull),
  .wrEn       (wrEn),
  .wrData     (wrData)
);

`default_nettype wire

// ==== tests/tb_frameSource.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frameSource import frameGenPkg::*; ();

  localparam int NUM_TESTS       = 6;
  localparam int BURSTS_PER_TEST = 2;
  localparam int FRAME_BYTES     = 2*TAG_BYTES + RECORDS_PER_FRAME*RECORD_BYTES;  // 100
  localparam int QUIET_CYCLES    = PERIOD_TICKS + 200;  // longer than one period
  localparam int HOLD_LEAD       = 24;   // hold starts this far ahead of the first burst
  localparam int HOLD_CYCLES     = 320;  // long enough to fill past FIFO_AF_LEVEL
  localparam int WATCHDOG_CYCLES =
    2 * NUM_TESTS * (BURSTS_PER_TEST + 1) * (PERIOD_TICKS + 500);

  logic                CLK = 1'b0;
  logic                RST;
  logic                nimIn;
  logic                regTrigger;
  logic [FRAMES_W-1:0] frameCount;
  logic                txFull;
  wire                 nimOut;
  wire                 txWr;
  wire  [BYTE_W-1:0]   txData;

  integer             seed         = 32'h8bf8;
  int                 errors       = 0;
  int                 checks       = 0;
  int                 curFrames    = 1;     // frames per burst in this test
  int                 burstIdx     = 0;     // bursts received in this test
  int                 frameInBurst = 0;
  int                 rxPos        = 0;     // byte within the frame
  logic               quiet        = 1'b1;  // no txWr expected
  logic               txFullPrev   = 1'b0;
  logic               holdFull     = 1'b0;  // tcp side blocked, builder must stall
  frameTag_u          rxHdr;
  frameTag_u          rxFtr;
  logic [STAMP_W-8:0] prevTime;

  frameSource i_frameSource (
    .CLK        (CLK),
    .RST        (RST),
    .nimIn      (nimIn),
    .regTrigger (regTrigger),
    .frameCount (frameCount),
    .txFull     (txFull),
    .nimOut     (nimOut),
    .txWr       (txWr),
    .txData     (txData)
  );

  always #2 CLK = ~CLK;  // 4 ns

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------
  task automatic compareByte(input string name, input logic [BYTE_W-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic compareTag(input string name, input frameTag_u got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic compareStamp(input string name, input logic [STAMP_W-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  task automatic compareFlag(input string name, input logic got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic reportError(input string what);
    errors++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  // ----------------------------------------------------------
  // frame model
  // ----------------------------------------------------------
  function automatic logic [BYTE_W-1:0] recordByte(input int k);
    return HIT_RECORD[(RECORD_BYTES-1-k)*BYTE_W +: BYTE_W];  // msb first
  endfunction

  task automatic checkFrame();
    frameTag_u          expHdr;
    frameTag_u          expFtr;
    frameTag_u          gotHdr;
    frameTag_u          gotFtr;
    logic [STAMP_W-1:0] expEvent;
    logic [STAMP_W-1:0] minTime;
    expEvent               = STAMP_W'(burstIdx + 1);  // cleared on disarm, +1 per wrap
    expHdr                 = '0;
    expHdr.hdr.marker      = HEADER_MARK;
    expHdr.hdr.address     = FRONTEND_ADDR;
    expHdr.hdr.last        = (frameInBurst == curFrames - 1);
    expHdr.hdr.length      = STAMP_W'(RECORDS_PER_FRAME);
    expFtr                 = expHdr;
    expFtr.ftr.marker      = FOOTER_MARK;
    gotHdr                 = rxHdr;
    gotHdr.hdr.eventNumber = '0;  // event numbers go through compareStamp
    gotFtr                 = rxFtr;
    gotFtr.ftr.timeStamp   = '0;  // time field has its own check
    gotFtr.ftr.eventNumber = '0;
    compareTag("header", gotHdr, expHdr);
    compareTag("footer", gotFtr, expFtr);
    compareStamp("header eventNumber", rxHdr.hdr.eventNumber, expEvent);
    compareStamp("footer eventNumber", rxFtr.ftr.eventNumber, expEvent);
    // first footer byte leaves 91 + 100 per earlier frame cycles after start at best
    minTime = STAMP_W'(FRAME_BYTES - TAG_BYTES + 1 + frameInBurst*FRAME_BYTES);
    if (rxFtr.ftr.timeStamp < minTime[STAMP_W-1:7]) begin
      reportError("footer time stamp is earlier than the frame could be built");
    end
    if (frameInBurst > 0 && rxFtr.ftr.timeStamp < prevTime) begin
      reportError("footer time stamp went backwards within a burst");
    end
    prevTime = rxFtr.ftr.timeStamp;
    frameInBurst++;
    if (frameInBurst == curFrames) begin
      frameInBurst = 0;
      burstIdx++;
    end
  endtask

  task automatic takeByte(input logic [BYTE_W-1:0] b);
    int recPos;
    if (rxPos < TAG_BYTES) begin
      rxHdr.bytes[TAG_BYTES-1-rxPos] = b;
    end else if (rxPos < FRAME_BYTES - TAG_BYTES) begin
      recPos = (rxPos - TAG_BYTES) % RECORD_BYTES;
      compareByte("txData record", b, recordByte(recPos));
    end else begin
      rxFtr.bytes[FRAME_BYTES-1-rxPos] = b;
    end
    if (rxPos == FRAME_BYTES - 1) begin
      rxPos = 0;
      checkFrame();
    end else begin
      rxPos++;
    end
  endtask

  // tcp side monitor, outputs settled at the falling edge
  always @(negedge CLK) begin
    if (!RST && txWr) begin
      if (txFullPrev) begin
        reportError("txWr high one cycle after txFull was high");
      end
      if (quiet) begin
        reportError("txWr appeared after disarm with the FIFO drained");
      end else begin
        takeByte(txData);
      end
    end
    txFullPrev = txFull;
  end

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------
  always @(posedge CLK) begin
    if (RST) begin
      txFull <= 1'b0;
    end else begin
      txFull <= holdFull | (($unsigned($random(seed)) % 100) < 30);  // about 30 percent busy
    end
  end

  task automatic runTest(input int t);
    int   frames;
    logic viaNim;
    int   errStart;
    @(negedge CLK);  // draw apart from the txFull draws
    frames = 1 + int'($unsigned($random(seed)) % 4);
    viaNim = ($random(seed) % 2) != 0;
    errStart = errors;
    @(posedge CLK);
    curFrames    = frames;
    burstIdx     = 0;
    frameInBurst = 0;
    quiet        = 1'b0;
    frameCount <= FRAMES_W'(frames);  // trigger is still off here
    @(posedge CLK);
    if (viaNim) begin
      nimIn <= 1'b1;
    end else begin
      regTrigger <= 1'b1;
    end
    @(negedge CLK);
    compareFlag("nimOut", nimOut, 1'b0);
    @(negedge CLK);
    compareFlag("nimOut", nimOut, 1'b1);  // echo one cycle later
    // block the tcp side across the start of the first burst
    repeat (PERIOD_TICKS - HOLD_LEAD) @(negedge CLK);
    holdFull = 1'b1;
    repeat (HOLD_CYCLES) @(negedge CLK);
    holdFull = 1'b0;
    while (burstIdx < BURSTS_PER_TEST) begin
      @(posedge CLK);
    end
    quiet = 1'b1;  // all bytes in, fifo empty
    @(posedge CLK);
    nimIn      <= 1'b0;
    regTrigger <= 1'b0;
    @(negedge CLK);
    compareFlag("nimOut", nimOut, 1'b1);
    @(negedge CLK);
    compareFlag("nimOut", nimOut, 1'b0);
    repeat (QUIET_CYCLES) @(posedge CLK);  // no burst may start while disarmed
    $display("test %0d: %s trigger, %0d frames x %0d bursts, %0d errors",
             t, viaNim ? "nim" : "register", frames, BURSTS_PER_TEST, errors - errStart);
  endtask

  initial begin
    RST        = 1'b1;
    nimIn      = 1'b0;
    regTrigger = 1'b0;
    frameCount = FRAMES_W'(1);
    txFull     = 1'b0;
    repeat (16) @(posedge CLK);
    RST <= 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      runTest(t);
    end
    errors += int'(i_frameSource.i_frameBuilder.i_builderRules.afFails);
    errors += int'(i_frameSource.i_frameBuilder.i_builderRules.idleFails);
    errors += int'(i_frameSource.i_frameBuilder.i_builderRules.markFails);
    $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== frameSource.f ====
design/frameGenPkg.sv
design/burstTimer.sv
design/frameBuilder.sv
design/txByteFifo.sv
design/frameSource.sv
tests/frameSource_assert.sv
tests/tb_frameSource.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"
mkdir -p "$BUILD_DIR"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_frameSource \
  -Mdir "$BUILD_DIR/obj" \
  -f frameSource.f

"./$BUILD_DIR/obj/Vtb_frameSource" +verilator+error+limit+100 | tee "$LOG"

if grep -q "Verification passed" "$LOG"; then
  echo "run.sh: simulation passed"
  exit 0
fi

echo "run.sh: simulation failed, see $LOG"
exit 1
